// File: src/osc_pkg.sv
/*
  oscilloscope capture channel package
  sample, stream and bus types, register map and default widths
*/
`default_nettype none

package osc_pkg;

  // ADC sample, signed
  typedef logic signed [15:0] smp_t;

  // stream word
  typedef struct packed {
    smp_t dat;
    logic lst;
  } stm_t;

  // system bus request and response
  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [6:0]  addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  ////////////////////////////////////////////////////////////
  // register offsets
  ////////////////////////////////////////////////////////////

  // control/status, event masks
  localparam logic [6:0] REG_CTL     = 7'h00;
  localparam logic [6:0] REG_MSK_STR = 7'h04;
  localparam logic [6:0] REG_MSK_STP = 7'h08;
  localparam logic [6:0] REG_MSK_TRG = 7'h0c;
  // interrupts
  localparam logic [6:0] REG_IRQ_ENA = 7'h10;
  localparam logic [6:0] REG_IRQ_STS = 7'h14;
  // pre/post trigger windows
  localparam logic [6:0] REG_PRE     = 7'h20;
  localparam logic [6:0] REG_PST     = 7'h24;
  localparam logic [6:0] REG_STS_PRE = 7'h28;
  localparam logic [6:0] REG_STS_PST = 7'h2c;
  // edge trigger
  localparam logic [6:0] REG_NEG     = 7'h30;
  localparam logic [6:0] REG_POS     = 7'h34;
  localparam logic [6:0] REG_EDG     = 7'h38;
  localparam logic [6:0] REG_HLD     = 7'h3c;
  // decimation
  localparam logic [6:0] REG_DEC     = 7'h40;
  localparam logic [6:0] REG_SHR     = 7'h44;
  localparam logic [6:0] REG_AVG     = 7'h48;

  // default widths
  parameter int unsigned CW_DEF  = 31;
  parameter int unsigned DCW_DEF = 17;
  parameter int unsigned DSW_DEF = 4;
  parameter int unsigned EW_DEF  = 5;

endpackage

`default_nettype wire

// File: src/osc_regs.sv
/*
  oscilloscope register block
  configuration, event routing into start/stop/trigger, interrupt status
*/
`timescale 1ns/1ps
`default_nettype none

module osc_regs #(
  parameter int unsigned CW  = 31,
  parameter int unsigned DCW = 17,
  parameter int unsigned DSW = 4,
  parameter int unsigned EW  = 5
) (
  input  wire                     bus_i,
  input  wire                     ctl_rst_i,
  // system bus
  input  wire  osc_pkg::bus_req_t bus_req_i,
  output osc_pkg::bus_rsp_t       bus_rsp_o,
  // event sources
  input  wire  [EW-1:0]           evn_ext_i,
  input  wire                     evn_lvl_i,
  // acquisition status
  input  wire                     sts_str_i,
  input  wire                     sts_stp_i,
  input  wire                     sts_trg_i,
  input  wire  [CW-1:0]           sts_pre_i,
  input  wire                     sts_pro_i,
  input  wire  [CW-1:0]           sts_pst_i,
  input  wire                     sts_pso_i,
  // configuration
  output logic [CW-1:0]           cfg_pre_o,
  output logic [CW-1:0]           cfg_pst_o,
  output osc_pkg::smp_t           cfg_neg_o,
  output osc_pkg::smp_t           cfg_pos_o,
  output logic                    cfg_edg_o,
  output logic [CW-1:0]           cfg_hld_o,
  output logic [DCW-1:0]          cfg_dec_o,
  output logic [DSW-1:0]          cfg_shr_o,
  output logic                    cfg_avg_o,
  // strobes into acquisition
  output logic                    ctl_str_o,
  output logic                    ctl_stp_o,
  output logic                    ctl_trg_o,
  output logic                    irq_o
);

  import osc_pkg::*;

  localparam int unsigned SW = $bits(smp_t);

  // event masks
  logic [EW-1:0] msk_str;
  logic [EW-1:0] msk_stp;
  logic [EW-1:0] msk_trg;
  // interrupt enable and sticky status
  // bits ordered trg stp str from the top
  logic [2:0]    irq_ena;
  logic [2:0]    irq_sts;
  logic [2:0]    irq_clr;
  logic          wr_ctl;

  assign wr_ctl  = bus_req_i.wen && (bus_req_i.addr == REG_CTL);
  assign irq_clr = (bus_req_i.wen && (bus_req_i.addr == REG_IRQ_STS)) ?
                   bus_req_i.wdata[2:0] : 3'b000;

  ////////////////////////////////////////////////////////////
  // configuration writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_i) begin
    if (ctl_rst_i) begin
      msk_str   <= '0;
      msk_stp   <= '0;
      msk_trg   <= '0;
      irq_ena   <= '0;
      cfg_pre_o <= '0;
      cfg_pst_o <= '0;
      cfg_neg_o <= '0;
      cfg_pos_o <= '0;
      cfg_edg_o <= 1'b0;
      cfg_hld_o <= '0;
      cfg_dec_o <= '0;
      cfg_shr_o <= '0;
      cfg_avg_o <= 1'b0;
    end else if (bus_req_i.wen) begin
      case (bus_req_i.addr)
        REG_MSK_STR: msk_str   <= bus_req_i.wdata[EW-1:0];
        REG_MSK_STP: msk_stp   <= bus_req_i.wdata[EW-1:0];
        REG_MSK_TRG: msk_trg   <= bus_req_i.wdata[EW-1:0];
        REG_IRQ_ENA: irq_ena   <= bus_req_i.wdata[2:0];
        REG_PRE:     cfg_pre_o <= bus_req_i.wdata[CW-1:0];
        REG_PST:     cfg_pst_o <= bus_req_i.wdata[CW-1:0];
        REG_NEG:     cfg_neg_o <= bus_req_i.wdata[SW-1:0];
        REG_POS:     cfg_pos_o <= bus_req_i.wdata[SW-1:0];
        REG_EDG:     cfg_edg_o <= bus_req_i.wdata[0];
        REG_HLD:     cfg_hld_o <= bus_req_i.wdata[CW-1:0];
        REG_DEC:     cfg_dec_o <= bus_req_i.wdata[DCW-1:0];
        REG_SHR:     cfg_shr_o <= bus_req_i.wdata[DSW-1:0];
        REG_AVG:     cfg_avg_o <= bus_req_i.wdata[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // strobes and interrupts
  ////////////////////////////////////////////////////////////

  // software pulse or masked external event
  // trigger also takes the edge detector level
  always_ff @(posedge bus_i) begin
    if (ctl_rst_i) begin
      ctl_str_o <= 1'b0;
      ctl_stp_o <= 1'b0;
      ctl_trg_o <= 1'b0;
      irq_sts   <= '0;
      irq_o     <= 1'b0;
    end else begin
      ctl_str_o <= (wr_ctl && bus_req_i.wdata[1]) || |(evn_ext_i & msk_str);
      ctl_stp_o <= (wr_ctl && bus_req_i.wdata[2]) || |(evn_ext_i & msk_stp);
      ctl_trg_o <= (wr_ctl && bus_req_i.wdata[3]) || |(evn_ext_i & msk_trg)
                   || evn_lvl_i;
      // new events win over a clear in the same cycle
      irq_sts   <= (irq_sts & ~irq_clr) | {ctl_trg_o, ctl_stp_o, ctl_str_o};
      irq_o     <= |(irq_sts & irq_ena);
    end
  end

  ////////////////////////////////////////////////////////////
  // bus response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_i) begin
    if (ctl_rst_i) begin
      bus_rsp_o.ack <= 1'b0;
    end else begin
      bus_rsp_o.ack <= bus_req_i.wen | bus_req_i.ren;
    end
  end

  // registered read mux lines data up with ack
  always_ff @(posedge bus_i) begin
    if (bus_req_i.ren) begin
      case (bus_req_i.addr)
        REG_CTL:     bus_rsp_o.rdata <= {28'd0, sts_trg_i, sts_stp_i, sts_str_i, 1'b0};
        REG_MSK_STR: bus_rsp_o.rdata <= 32'(msk_str);
        REG_MSK_STP: bus_rsp_o.rdata <= 32'(msk_stp);
        REG_MSK_TRG: bus_rsp_o.rdata <= 32'(msk_trg);
        REG_IRQ_ENA: bus_rsp_o.rdata <= 32'(irq_ena);
        REG_IRQ_STS: bus_rsp_o.rdata <= 32'(irq_sts);
        REG_PRE:     bus_rsp_o.rdata <= 32'(cfg_pre_o);
        REG_PST:     bus_rsp_o.rdata <= 32'(cfg_pst_o);
        REG_STS_PRE: bus_rsp_o.rdata <= {sts_pro_i, 31'(sts_pre_i)};
        REG_STS_PST: bus_rsp_o.rdata <= {sts_pso_i, 31'(sts_pst_i)};
        REG_NEG:     bus_rsp_o.rdata <= 32'($unsigned(cfg_neg_o));
        REG_POS:     bus_rsp_o.rdata <= 32'($unsigned(cfg_pos_o));
        REG_EDG:     bus_rsp_o.rdata <= 32'(cfg_edg_o);
        REG_HLD:     bus_rsp_o.rdata <= 32'(cfg_hld_o);
        REG_DEC:     bus_rsp_o.rdata <= 32'(cfg_dec_o);
        REG_SHR:     bus_rsp_o.rdata <= 32'(cfg_shr_o);
        REG_AVG:     bus_rsp_o.rdata <= 32'(cfg_avg_o);
        default:     bus_rsp_o.rdata <= '0;
      endcase
    end
  end

  // request lasts one cycle and gets its ack in the next
  a_ack: assert property (@(posedge bus_i) disable iff (ctl_rst_i)
    (bus_req_i.wen || bus_req_i.ren) |=>
      bus_rsp_o.ack && !bus_req_i.wen && !bus_req_i.ren);

endmodule

`default_nettype wire

// File: src/osc_decim.sv
/*
  decimator, one output per N accepted samples
  optional averaging: group sum shifted right
*/
`timescale 1ns/1ps
`default_nettype none

module osc_decim #(
  parameter int unsigned DCW = 17,
  parameter int unsigned DSW = 4
) (
  input  wire                  bus_i,
  input  wire                  ctl_rst_i,
  input  wire  [DCW-1:0]       cfg_dec_i,
  input  wire  [DSW-1:0]       cfg_shr_i,
  input  wire                  cfg_avg_i,
  // input stream
  input  wire  osc_pkg::stm_t  sti_dat_i,
  input  wire                  sti_vld_i,
  output logic                 sti_rdy_o,
  // output stream
  output osc_pkg::stm_t        sto_dat_o,
  output logic                 sto_vld_o,
  input  wire                  sto_rdy_i
);

  import osc_pkg::*;

  // accumulator wide enough for a full group
  localparam int unsigned AW = $bits(smp_t) + DCW;

  logic [DCW-1:0]        cnt_q;
  logic [DCW-1:0]        dec_n;
  logic signed [AW-1:0]  acc_q;
  logic signed [AW-1:0]  acc_sum;
  logic signed [AW-1:0]  acc_shr;
  logic                  acc_en;
  logic                  grp_end;

  // factor 0 behaves as 1
  assign dec_n   = (cfg_dec_i == '0) ? DCW'(1) : cfg_dec_i;
  assign grp_end = cnt_q >= (dec_n - 1'b1);
  assign acc_sum = acc_q + sti_dat_i.dat;
  assign acc_shr = acc_sum >>> cfg_shr_i;

  // holding register free or being emptied
  assign sti_rdy_o = ~sto_vld_o | sto_rdy_i;
  assign acc_en    = sti_vld_i & sti_rdy_o;

  always_ff @(posedge bus_i) begin
    if (ctl_rst_i) begin
      cnt_q     <= '0;
      acc_q     <= '0;
      sto_vld_o <= 1'b0;
    end else begin
      if (sto_rdy_i) sto_vld_o <= 1'b0;
      if (acc_en) begin
        if (grp_end) begin
          // close group, restart sum
          cnt_q     <= '0;
          acc_q     <= '0;
          sto_vld_o <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
          acc_q <= acc_sum;
        end
      end
    end
  end

  // output payload
  always_ff @(posedge bus_i) begin
    if (acc_en && grp_end) begin
      sto_dat_o.dat <= cfg_avg_i ? acc_shr[$bits(smp_t)-1:0] : sti_dat_i.dat;
      sto_dat_o.lst <= sti_dat_i.lst;
    end
  end

  // stalled output holds its word
  a_stall: assert property (@(posedge bus_i) disable iff (ctl_rst_i)
    sto_vld_o && !sto_rdy_i |=> sto_vld_o && $stable(sto_dat_o));

endmodule

`default_nettype wire

// File: src/osc_edge.sv
/*
  edge trigger with hysteresis and hold-off
  one register stage, evn_lvl_o marks the triggering sample
*/
`timescale 1ns/1ps
`default_nettype none

module osc_edge #(
  parameter int unsigned CW = 31
) (
  input  wire                  bus_i,
  input  wire                  ctl_rst_i,
  input  wire  osc_pkg::smp_t  cfg_neg_i,
  input  wire  osc_pkg::smp_t  cfg_pos_i,
  // 0 rising, 1 falling
  input  wire                  cfg_edg_i,
  input  wire  [CW-1:0]        cfg_hld_i,
  // input stream
  input  wire  osc_pkg::stm_t  sti_dat_i,
  input  wire                  sti_vld_i,
  output logic                 sti_rdy_o,
  // output stream
  output osc_pkg::stm_t        sto_dat_o,
  output logic                 sto_vld_o,
  input  wire                  sto_rdy_i,
  output logic                 evn_lvl_o
);

  import osc_pkg::*;

  logic          arm_q;
  logic [CW-1:0] hld_q;
  logic          acc_en;
  logic          below;
  logic          above;
  logic          hld_act;
  logic          fire;

  assign sti_rdy_o = ~sto_vld_o | sto_rdy_i;
  assign acc_en    = sti_vld_i & sti_rdy_o;

  // threshold compare
  assign below   = sti_dat_i.dat < cfg_neg_i;
  assign above   = sti_dat_i.dat > cfg_pos_i;
  assign hld_act = hld_q != '0;
  // rising: arm low, fire high. falling mirrors
  assign fire    = arm_q && !hld_act && (cfg_edg_i ? below : above);

  always_ff @(posedge bus_i) begin
    if (ctl_rst_i) begin
      arm_q     <= 1'b0;
      hld_q     <= '0;
      sto_vld_o <= 1'b0;
      evn_lvl_o <= 1'b0;
    end else begin
      evn_lvl_o <= acc_en && fire;
      if (sto_rdy_i) sto_vld_o <= 1'b0;
      if (acc_en) begin
        sto_vld_o <= 1'b1;
        if (fire) begin
          arm_q <= 1'b0;
          hld_q <= cfg_hld_i;
        end else if (hld_act) begin
          // hold-off counts accepted samples, crossings ignored
          hld_q <= hld_q - 1'b1;
        end else if (cfg_edg_i ? above : below) begin
          arm_q <= 1'b1;
        end
      end
    end
  end

  // output payload
  always_ff @(posedge bus_i) begin
    if (acc_en) sto_dat_o <= sti_dat_i;
  end

endmodule

`default_nettype wire

// File: src/osc_acq.sv
/*
  acquisition controller
  pre-trigger and post-trigger windows, stream gating and last flag
*/
`timescale 1ns/1ps
`default_nettype none

module osc_acq #(
  parameter int unsigned CW = 31
) (
  input  wire                  bus_i,
  input  wire                  ctl_rst_i,
  // strobes
  input  wire                  ctl_str_i,
  input  wire                  ctl_stp_i,
  input  wire                  ctl_trg_i,
  input  wire  [CW-1:0]        cfg_pre_i,
  input  wire  [CW-1:0]        cfg_pst_i,
  // input stream
  input  wire  osc_pkg::stm_t  sti_dat_i,
  input  wire                  sti_vld_i,
  output logic                 sti_rdy_o,
  // output stream
  output osc_pkg::stm_t        sto_dat_o,
  output logic                 sto_vld_o,
  input  wire                  sto_rdy_i,
  // status
  output logic                 sts_str_o,
  output logic                 sts_stp_o,
  output logic                 sts_trg_o,
  output logic [CW-1:0]        sts_pre_o,
  output logic                 sts_pro_o,
  output logic [CW-1:0]        sts_pst_o,
  output logic                 sts_pso_o,
  output logic                 evn_lst_o
);

  import osc_pkg::*;

  logic pre_ok;
  logic pst_end;
  logic xfr;

  // pre window filled, saturated count also counts
  assign pre_ok  = sts_pro_o || (sts_pre_o >= cfg_pre_i);
  // this transfer brings post count to cfg_pst
  assign pst_end = ({1'b0, sts_pst_o} + 1'b1) >= {1'b0, cfg_pst_i};

  ////////////////////////////////////////////////////////////
  // stream gating, zero latency
  ////////////////////////////////////////////////////////////

  // idle: drain input, send nothing
  assign sti_rdy_o     = ~sts_str_o | sto_rdy_i;
  assign sto_vld_o     = sts_str_o & sti_vld_i;
  assign sto_dat_o.dat = sti_dat_i.dat;
  assign sto_dat_o.lst = sts_str_o & sts_trg_o & pst_end;
  assign xfr           = sto_vld_o & sto_rdy_i;
  assign evn_lst_o     = xfr & sto_dat_o.lst;

  always_ff @(posedge bus_i) begin
    if (ctl_rst_i) begin
      sts_str_o <= 1'b0;
      sts_stp_o <= 1'b0;
      sts_trg_o <= 1'b0;
      sts_pre_o <= '0;
      sts_pro_o <= 1'b0;
      sts_pst_o <= '0;
      sts_pso_o <= 1'b0;
    end else if (ctl_str_i) begin
      // new acquisition
      sts_str_o <= 1'b1;
      sts_stp_o <= 1'b0;
      sts_trg_o <= 1'b0;
      sts_pre_o <= '0;
      sts_pro_o <= 1'b0;
      sts_pst_o <= '0;
      sts_pso_o <= 1'b0;
    end else if (sts_str_o) begin
      if (ctl_stp_i || evn_lst_o) begin
        sts_str_o <= 1'b0;
        sts_stp_o <= 1'b1;
      end
      if (ctl_trg_i && !sts_trg_o && pre_ok) sts_trg_o <= 1'b1;
      // saturating counters, advance on transfers only
      if (xfr && !sts_trg_o) begin
        if (&sts_pre_o) sts_pro_o <= 1'b1;
        else            sts_pre_o <= sts_pre_o + 1'b1;
      end
      if (xfr && sts_trg_o) begin
        if (&sts_pst_o) sts_pso_o <= 1'b1;
        else            sts_pst_o <= sts_pst_o + 1'b1;
      end
    end
  end

  // last only after a trigger that came past a full pre window
  a_lst: assert property (@(posedge bus_i) disable iff (ctl_rst_i)
    sto_vld_o && sto_dat_o.lst |-> sts_trg_o && pre_ok);

endmodule

`default_nettype wire

// File: src/osc_top.sv
/*
  oscilloscope capture channel
  decimator, edge trigger and acquisition, configured over the system bus
*/
`timescale 1ns/1ps
`default_nettype none

module osc_top #(
  parameter int unsigned CW  = osc_pkg::CW_DEF,
  parameter int unsigned DCW = osc_pkg::DCW_DEF,
  parameter int unsigned DSW = osc_pkg::DSW_DEF,
  parameter int unsigned EW  = osc_pkg::EW_DEF
) (
  input  wire                     bus_i,
  input  wire                     ctl_rst_i,
  // system bus
  input  wire  osc_pkg::bus_req_t bus_req_i,
  output osc_pkg::bus_rsp_t       bus_rsp_o,
  // input stream
  input  wire  osc_pkg::stm_t     sti_dat_i,
  input  wire                     sti_vld_i,
  output logic                    sti_rdy_o,
  // output stream
  output osc_pkg::stm_t           sto_dat_o,
  output logic                    sto_vld_o,
  input  wire                     sto_rdy_i,
  // events
  input  wire  [EW-1:0]           evn_ext_i,
  output logic                    evn_lvl_o,
  output logic                    evn_lst_o,
  output logic                    irq_o
);

  import osc_pkg::*;

  // configuration
  logic [CW-1:0]  cfg_pre;
  logic [CW-1:0]  cfg_pst;
  smp_t           cfg_neg;
  smp_t           cfg_pos;
  logic           cfg_edg;
  logic [CW-1:0]  cfg_hld;
  logic [DCW-1:0] cfg_dec;
  logic [DSW-1:0] cfg_shr;
  logic           cfg_avg;
  // strobes and acquisition status
  logic           ctl_str;
  logic           ctl_stp;
  logic           ctl_trg;
  logic           sts_str;
  logic           sts_stp;
  logic           sts_trg;
  logic [CW-1:0]  sts_pre;
  logic           sts_pro;
  logic [CW-1:0]  sts_pst;
  logic           sts_pso;
  // decimator to edge, edge to acquisition
  stm_t           std_dat;
  logic           std_vld;
  logic           std_rdy;
  stm_t           ste_dat;
  logic           ste_vld;
  logic           ste_rdy;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  osc_regs #(.CW(CW), .DCW(DCW), .DSW(DSW), .EW(EW)) regs0 (
    .bus_i     (bus_i),     .ctl_rst_i (ctl_rst_i),
    .bus_req_i (bus_req_i), .bus_rsp_o (bus_rsp_o),
    .evn_ext_i (evn_ext_i), .evn_lvl_i (evn_lvl_o),
    .sts_str_i (sts_str),   .sts_stp_i (sts_stp),   .sts_trg_i (sts_trg),
    .sts_pre_i (sts_pre),   .sts_pro_i (sts_pro),
    .sts_pst_i (sts_pst),   .sts_pso_i (sts_pso),
    .cfg_pre_o (cfg_pre),   .cfg_pst_o (cfg_pst),
    .cfg_neg_o (cfg_neg),   .cfg_pos_o (cfg_pos),
    .cfg_edg_o (cfg_edg),   .cfg_hld_o (cfg_hld),
    .cfg_dec_o (cfg_dec),   .cfg_shr_o (cfg_shr),   .cfg_avg_o (cfg_avg),
    .ctl_str_o (ctl_str),   .ctl_stp_o (ctl_stp),   .ctl_trg_o (ctl_trg),
    .irq_o     (irq_o)
  );

  ////////////////////////////////////////////////////////////
  // stream chain
  ////////////////////////////////////////////////////////////

  osc_decim #(.DCW(DCW), .DSW(DSW)) decim0 (
    .bus_i     (bus_i),     .ctl_rst_i (ctl_rst_i),
    .cfg_dec_i (cfg_dec),   .cfg_shr_i (cfg_shr),   .cfg_avg_i (cfg_avg),
    .sti_dat_i (sti_dat_i), .sti_vld_i (sti_vld_i), .sti_rdy_o (sti_rdy_o),
    .sto_dat_o (std_dat),   .sto_vld_o (std_vld),   .sto_rdy_i (std_rdy)
  );

  osc_edge #(.CW(CW)) edge0 (
    .bus_i     (bus_i),     .ctl_rst_i (ctl_rst_i),
    .cfg_neg_i (cfg_neg),   .cfg_pos_i (cfg_pos),
    .cfg_edg_i (cfg_edg),   .cfg_hld_i (cfg_hld),
    .sti_dat_i (std_dat),   .sti_vld_i (std_vld),   .sti_rdy_o (std_rdy),
    .sto_dat_o (ste_dat),   .sto_vld_o (ste_vld),   .sto_rdy_i (ste_rdy),
    .evn_lvl_o (evn_lvl_o)
  );

  osc_acq #(.CW(CW)) acq0 (
    .bus_i     (bus_i),     .ctl_rst_i (ctl_rst_i),
    .ctl_str_i (ctl_str),   .ctl_stp_i (ctl_stp),   .ctl_trg_i (ctl_trg),
    .cfg_pre_i (cfg_pre),   .cfg_pst_i (cfg_pst),
    .sti_dat_i (ste_dat),   .sti_vld_i (ste_vld),   .sti_rdy_o (ste_rdy),
    .sto_dat_o (sto_dat_o), .sto_vld_o (sto_vld_o), .sto_rdy_i (sto_rdy_i),
    .sts_str_o (sts_str),   .sts_stp_o (sts_stp),   .sts_trg_o (sts_trg),
    .sts_pre_o (sts_pre),   .sts_pro_o (sts_pro),
    .sts_pst_o (sts_pst),   .sts_pso_o (sts_pso),
    .evn_lst_o (evn_lst_o)
  );

endmodule

`default_nettype wire

// File: test/osc_tb.sv
/*
  testbench for the oscilloscope capture channel
  replays bus accesses and sample ramps from a trace, checks the output stream
*/
`timescale 1ns/1ps
`default_nettype none

module osc_tb;

  import osc_pkg::*;

  localparam int unsigned PERIOD  = 8;
  localparam int unsigned RST_CYC = 16;
  // strobe, irq status and irq_o register stages
  localparam int unsigned SETTLE  = 4;
  // cycles per trace record, a ramp under back-pressure included
  localparam int unsigned REC_CYC = 200;

  logic              bus_i;
  logic              ctl_rst_i;
  bus_req_t          bus_req_i;
  bus_rsp_t          bus_rsp_o;
  stm_t              sti_dat_i;
  logic              sti_vld_i;
  logic              sti_rdy_o;
  stm_t              sto_dat_o;
  logic              sto_vld_o;
  logic              sto_rdy_i;
  logic [EW_DEF-1:0] evn_ext_i;
  logic              evn_lvl_o;
  logic              evn_lst_o;
  logic              irq_o;

  // trace records and expected output words
  string       lines[$];
  stm_t        exp_q[$];
  int          n_err;
  int          n_chk;
  int          lvl_cnt;
  int          lst_cnt;
  int          lim_cyc;
  logic        mon_on;
  logic        bp_on;
  logic [31:0] lcg_q;

  osc_top dut0 (
    .bus_i     (bus_i),
    .ctl_rst_i (ctl_rst_i),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .sti_dat_i (sti_dat_i),
    .sti_vld_i (sti_vld_i),
    .sti_rdy_o (sti_rdy_o),
    .sto_dat_o (sto_dat_o),
    .sto_vld_o (sto_vld_o),
    .sto_rdy_i (sto_rdy_i),
    .evn_ext_i (evn_ext_i),
    .evn_lvl_o (evn_lvl_o),
    .evn_lst_o (evn_lst_o),
    .irq_o     (irq_o)
  );

  initial begin
    bus_i = 1'b0;
    forever #(PERIOD / 2) bus_i = ~bus_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // output ready, random only while back-pressure is on
  initial begin
    lcg_q     = 32'hc1;
    sto_rdy_i = 1'b1;
    forever begin
      @(negedge bus_i);
      lcg_q     = lcg_next(lcg_q);
      sto_rdy_i = bp_on ? lcg_q[16] : 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    n_chk++;
    if (got !== want) begin
      n_err++;
      $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
    end
  endtask

  // one request cycle, ack next cycle, idle the cycle after
  task automatic bus_access(input logic wr, input logic [6:0] a, input logic [31:0] d,
                            output logic [31:0] rd);
    @(negedge bus_i);
    bus_req_i = '{wen: wr, ren: ~wr, addr: a, wdata: d};
    @(negedge bus_i);
    bus_req_i = '0;
    rd = bus_rsp_o.rdata;
    check_val("bus_rsp_o.ack", 32'(bus_rsp_o.ack), 32'd1);
    @(negedge bus_i);
    check_val("bus_rsp_o.ack", 32'(bus_rsp_o.ack), 32'd0);
  endtask

  // hold valid until the decimator takes the word
  task automatic drive_sample(input smp_t v);
    @(negedge bus_i);
    sti_dat_i = '{dat: v, lst: 1'b0};
    sti_vld_i = 1'b1;
    #2;
    while (!sti_rdy_o) begin
      @(negedge bus_i);
      #2;
    end
    @(posedge bus_i);
  endtask

  task automatic drain_stream();
    while (exp_q.size() != 0) @(negedge bus_i);
    repeat (SETTLE) @(posedge bus_i);
  endtask

  // pulse counts since the previous check, irq_o level
  task automatic check_pulses(input int lvl, input int lst, input int irq);
    repeat (SETTLE) @(posedge bus_i);
    @(negedge bus_i);
    check_val("evn_lvl_o pulses", lvl_cnt, lvl);
    check_val("evn_lst_o pulses", lst_cnt, lst);
    check_val("irq_o", 32'(irq_o), irq);
    lvl_cnt = 0;
    lst_cnt = 0;
  endtask

  task automatic load_trace(output logic ok);
    int    fd;
    string txt;
    fd = $fopen("test/osc_trace.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        txt = "";
        void'($fgets(txt, fd));
        // blank lines and comments hold no record
        if (txt.len() > 1 && txt.getc(0) != "#") lines.push_back(txt);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_record(input string txt);
    byte         kind;
    string       args;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    int          a0;
    int          a1;
    int          a2;
    int          a3;
    stm_t        w;
    kind = txt.getc(0);
    args = txt.substr(1, txt.len() - 1);
    case (kind)
      "W", "R": begin
        void'($sscanf(args, "%h %h", addr, data));
        bus_access(kind == "W", addr[6:0], data, rd);
        if (kind == "R") check_val($sformatf("bus_rsp_o.rdata (addr 0x%02h)", addr[6:0]),
                                   rd, data);
      end
      "S": begin
        void'($sscanf(args, "%d %d %d", a0, a1, a2));
        for (int i = 0; i < a2; i++) drive_sample(smp_t'(a0 + i * a1));
        @(negedge bus_i);
        sti_vld_i = 1'b0;
        drain_stream();
      end
      "E": begin
        void'($sscanf(args, "%d %d %d %d", a0, a1, a2, a3));
        for (int i = 0; i < a2; i++) begin
          w.dat = smp_t'(a0 + i * a1);
          // last flag only on the final word of the record
          w.lst = (i == a2 - 1) && (a3 != 0);
          exp_q.push_back(w);
        end
      end
      "B": begin
        void'($sscanf(args, "%d", a0));
        bp_on = (a0 != 0);
      end
      "P": begin
        void'($sscanf(args, "%d %d %d", a0, a1, a2));
        check_pulses(a0, a1, a2);
      end
      default: begin
        n_err++;
        $display("trace holds a record of unknown type %c", kind);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor and watchdog
  ////////////////////////////////////////////////////////////

  // sampled mid-cycle, a transfer here completes on the next rising edge
  initial begin : out_mon
    stm_t want;
    wait (mon_on);
    forever begin
      @(negedge bus_i);
      #2;
      if (evn_lvl_o) lvl_cnt++;
      if (evn_lst_o) lst_cnt++;
      if (sto_vld_o && sto_rdy_i) begin
        if (exp_q.size() == 0) begin
          n_err++;
          $display("output sample 0x%04h at %0d ns was not expected", sto_dat_o.dat, $time);
        end else begin
          want = exp_q.pop_front();
          check_val("sto_dat_o.dat", 32'(sto_dat_o.dat), 32'(want.dat));
          check_val("sto_dat_o.lst", 32'(sto_dat_o.lst), 32'(want.lst));
        end
      end
    end
  end

  initial begin : watchdog
    wait (lim_cyc != 0);
    repeat (lim_cyc) @(posedge bus_i);
    $display("watchdog ran out after %0d cycles, a handshake never completed", lim_cyc);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    logic ok;
    ctl_rst_i = 1'b1;
    bus_req_i = '0;
    sti_dat_i = '0;
    sti_vld_i = 1'b0;
    evn_ext_i = '0;
    n_err     = 0;
    n_chk     = 0;
    lvl_cnt   = 0;
    lst_cnt   = 0;
    mon_on    = 1'b0;
    bp_on     = 1'b0;
    load_trace(ok);
    if (ok) begin
      lim_cyc = lines.size() * REC_CYC + RST_CYC;
      repeat (RST_CYC) @(posedge bus_i);
      @(negedge bus_i);
      ctl_rst_i = 1'b0;
      mon_on    = 1'b1;
      foreach (lines[i]) run_record(lines[i]);
      if (exp_q.size() != 0) begin
        n_err++;
        $display("%0d expected output samples never arrived", exp_q.size());
      end
    end else begin
      n_err++;
      $display("trace file test/osc_trace.txt could not be opened");
    end
    $display("checks: %0d, errors: %0d", n_chk, n_err);
    if (n_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/osc_trace.txt
# W addr data : bus write, R addr data : bus read and expected data (hex)
# S first step count : input ramp, E first step count last : expected outputs (decimal)
# B on : random output back-pressure, P lvl lst irq : pulses since last P and irq_o level
W 20 00000002
W 24 80000003
W 30 abcdfff6
W 34 00000014
W 3c 00000002
W 40 fffe0003
W 10 00000004
R 24 00000003
R 30 0000fff6
R 40 00000003
W 00 00000002
B 1
E 2 3 4 0
S 0 1 12
W 48 00000001
W 44 000000f1
R 44 00000001
E 9 9 2 0
S 4 2 6
P 0 0 0
B 0
W 48 00000000
W 40 00000001
E -30 10 7 0
S -30 10 7
P 1 0 1
R 14 00000005
E -40 80 3 1
S -40 80 3
P 0 1 1
R 28 0000000d
R 2c 00000003
R 00 0000000c
W 14 00000007
R 14 00000000
P 0 0 0

// File: sources.f
src/osc_pkg.sv
src/osc_regs.sv
src/osc_decim.sv
src/osc_edge.sv
src/osc_acq.sv
src/osc_top.sv
test/osc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the capture channel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module osc_tb -f sources.f -o osc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/osc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
